// ==== rtl/mc_pkg.sv ====
package mc_pkg;

    parameter int xlen = 32;

    typedef enum logic [6:0] {
        op_rtype  = 7'b0110011,
        op_itype  = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011
    } opcode_t;

    typedef enum logic [2:0] {
        st_fetch          = 3'd0,
        st_decode         = 3'd1,
        st_execute        = 3'd2,
        st_mem_access     = 3'd3,
        st_load_writeback = 3'd4
    } state_t;

    typedef enum logic [1:0] {
        alu_add     = 2'd0, // addresses and pc
        alu_sub_cmp = 2'd1, // branch compare
        alu_funct   = 2'd2  // from funct3/funct7
    } alu_class_t;

    typedef struct packed {
        logic       pc_write;
        logic       pc_write_cond;
        logic       branch_ne;
        logic       i_or_d;
        logic       mem_read;
        logic       mem_write;
        logic       ir_write;
        logic       reg_write;
        logic       mem_to_reg;
        logic       pc_source;
        alu_class_t alu_class;
        logic       alu_src_a;  // 0 pc, 1 a
        logic [1:0] alu_src_b;  // 0 b, 1 four, 2 imm
    } ctrl_t;

endpackage

// ==== rtl/alu.sv ====
module alu (
    input  logic [mc_pkg::xlen-1:0] a,
    input  logic [mc_pkg::xlen-1:0] b,
    input  mc_pkg::alu_class_t      alu_class,
    input  logic [2:0]              funct3,
    input  logic                    funct7_5,
    output logic [mc_pkg::xlen-1:0] result,
    output logic                    zero
);

    typedef enum logic [2:0] {
        op_add, op_sub, op_and, op_or, op_xor, op_slt
    } alu_op_t;

    alu_op_t op;

    always_comb begin
        op = op_add;
        case (alu_class)
            mc_pkg::alu_sub_cmp: op = op_sub;
            mc_pkg::alu_funct: begin
                case (funct3)
                    3'b000:  op = funct7_5 ? op_sub : op_add;
                    3'b010:  op = op_slt;
                    3'b100:  op = op_xor;
                    3'b110:  op = op_or;
                    3'b111:  op = op_and;
                    default: op = op_add;
                endcase
            end
            default: op = op_add;
        endcase
    end

    always_comb begin
        case (op)
            op_sub:  result = a - b;
            op_and:  result = a & b;
            op_or:   result = a | b;
            op_xor:  result = a ^ b;
            op_slt:  result = {{(mc_pkg::xlen-1){1'b0}}, $signed(a) < $signed(b)};
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

// ==== rtl/register_file.sv ====
module register_file (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [4:0]              rs1,
    input  logic [4:0]              rs2,
    input  logic [4:0]              rd,
    input  logic                    we,
    input  logic [mc_pkg::xlen-1:0] wdata,
    output logic [mc_pkg::xlen-1:0] rdata1,
    output logic [mc_pkg::xlen-1:0] rdata2
);

    logic [mc_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin // x0 stays zero
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

endmodule

// ==== rtl/unified_memory.sv ====
module unified_memory #(
    parameter int mem_words = 256
) (
    input  logic                    clk,
    input  logic [mc_pkg::xlen-1:0] addr,
    input  logic                    we,
    input  logic [mc_pkg::xlen-1:0] wdata,
    input  logic                    host_we,
    input  logic [mc_pkg::xlen-1:0] host_addr,
    input  logic [mc_pkg::xlen-1:0] host_wdata,
    output logic [mc_pkg::xlen-1:0] rdata,
    output logic [mc_pkg::xlen-1:0] host_rdata
);

    localparam int aw = $clog2(mem_words);

    logic [mc_pkg::xlen-1:0] mem [mem_words];

    always_ff @(posedge clk) begin
        if (host_we) begin // host wins
            mem[host_addr[aw+1:2]] <= host_wdata;
        end else if (we) begin
            mem[addr[aw+1:2]] <= wdata;
        end
    end

    assign rdata      = mem[addr[aw+1:2]];
    assign host_rdata = mem[host_addr[aw+1:2]];

endmodule

// ==== rtl/control_unit.sv ====
module control_unit (
    input  logic            clk,
    input  logic            reset,
    input  mc_pkg::opcode_t opcode,
    input  logic [2:0]      funct3,
    output mc_pkg::ctrl_t   ctrl,
    output logic            retire
);

    mc_pkg::state_t state;
    mc_pkg::state_t state_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mc_pkg::st_fetch;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = mc_pkg::st_fetch;
        case (state)
            mc_pkg::st_fetch:  state_next = mc_pkg::st_decode;
            mc_pkg::st_decode: state_next = mc_pkg::st_execute;
            mc_pkg::st_execute: begin
                case (opcode)
                    mc_pkg::op_rtype, mc_pkg::op_itype,
                    mc_pkg::op_load, mc_pkg::op_store: state_next = mc_pkg::st_mem_access;
                    default:                           state_next = mc_pkg::st_fetch;
                endcase
            end
            mc_pkg::st_mem_access: begin
                if (opcode == mc_pkg::op_load) begin
                    state_next = mc_pkg::st_load_writeback;
                end
            end
            default: state_next = mc_pkg::st_fetch;
        endcase
    end

    always_comb begin
        ctrl = '0;
        retire = 1'b0;
        if (!reset) begin // hold all enables low in reset
            case (state)
                mc_pkg::st_fetch: begin
                    ctrl.mem_read = 1'b1;
                    ctrl.ir_write = 1'b1;
                    ctrl.pc_write = 1'b1;
                    ctrl.alu_src_b = 2'd1; // pc + 4
                end
                mc_pkg::st_decode: begin
                    ctrl.alu_src_b = 2'd2; // branch target into aluout
                end
                mc_pkg::st_execute: begin
                    case (opcode)
                        mc_pkg::op_rtype: begin
                            ctrl.alu_src_a = 1'b1;
                            ctrl.alu_class = mc_pkg::alu_funct;
                        end
                        mc_pkg::op_itype: begin
                            ctrl.alu_src_a = 1'b1;
                            ctrl.alu_src_b = 2'd2;
                            ctrl.alu_class = mc_pkg::alu_funct;
                        end
                        mc_pkg::op_load, mc_pkg::op_store: begin
                            ctrl.alu_src_a = 1'b1;
                            ctrl.alu_src_b = 2'd2;
                        end
                        mc_pkg::op_branch: begin
                            ctrl.alu_src_a = 1'b1;
                            ctrl.alu_class = mc_pkg::alu_sub_cmp;
                            ctrl.pc_write_cond = 1'b1;
                            ctrl.pc_source = 1'b1;
                            ctrl.branch_ne = funct3[0];
                            retire = 1'b1;
                        end
                        default: retire = 1'b1; // unknown opcode, no effect
                    endcase
                end
                mc_pkg::st_mem_access: begin
                    case (opcode)
                        mc_pkg::op_load: begin
                            ctrl.mem_read = 1'b1;
                            ctrl.i_or_d = 1'b1;
                        end
                        mc_pkg::op_store: begin
                            ctrl.mem_write = 1'b1;
                            ctrl.i_or_d = 1'b1;
                            retire = 1'b1;
                        end
                        default: begin
                            ctrl.reg_write = 1'b1;
                            retire = 1'b1;
                        end
                    endcase
                end
                mc_pkg::st_load_writeback: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.mem_to_reg = 1'b1;
                    retire = 1'b1;
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== rtl/datapath.sv ====
module datapath (
    input  logic                    clk,
    input  logic                    reset,
    input  mc_pkg::ctrl_t           ctrl,
    input  logic [mc_pkg::xlen-1:0] mem_rdata,
    output mc_pkg::opcode_t         opcode,
    output logic [2:0]              funct3,
    output logic [mc_pkg::xlen-1:0] mem_addr,
    output logic [mc_pkg::xlen-1:0] mem_wdata,
    output logic [mc_pkg::xlen-1:0] pc
);

    logic [mc_pkg::xlen-1:0] ir;
    logic [mc_pkg::xlen-1:0] mdr;
    logic [mc_pkg::xlen-1:0] a_reg;
    logic [mc_pkg::xlen-1:0] b_reg;
    logic [mc_pkg::xlen-1:0] alu_out;
    logic [mc_pkg::xlen-1:0] rdata1;
    logic [mc_pkg::xlen-1:0] rdata2;
    logic [mc_pkg::xlen-1:0] imm;
    logic [mc_pkg::xlen-1:0] src_a;
    logic [mc_pkg::xlen-1:0] src_b;
    logic [mc_pkg::xlen-1:0] alu_result;
    logic [mc_pkg::xlen-1:0] wb_data;
    logic                    zero;
    logic                    funct7_5;
    logic                    pc_en;

    assign opcode = mc_pkg::opcode_t'(ir[6:0]);
    assign funct3 = ir[14:12];
    assign funct7_5 = ir[30] && (opcode == mc_pkg::op_rtype); // no sub for addi

    always_comb begin
        case (opcode)
            mc_pkg::op_store:  imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            mc_pkg::op_branch: imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            default:           imm = {{20{ir[31]}}, ir[31:20]};
        endcase
    end

    assign src_a = ctrl.alu_src_a ? a_reg : pc;

    always_comb begin
        case (ctrl.alu_src_b)
            2'd0:    src_b = b_reg;
            2'd1:    src_b = mc_pkg::xlen'(4);
            default: src_b = imm;
        endcase
    end

    alu u_alu (
        .a         (src_a),
        .b         (src_b),
        .alu_class (ctrl.alu_class),
        .funct3    (funct3),
        .funct7_5  (funct7_5),
        .result    (alu_result),
        .zero      (zero)
    );

    assign wb_data = ctrl.mem_to_reg ? mdr : alu_out;

    register_file u_regs (
        .clk    (clk),
        .reset  (reset),
        .rs1    (ir[19:15]),
        .rs2    (ir[24:20]),
        .rd     (ir[11:7]),
        .we     (ctrl.reg_write),
        .wdata  (wb_data),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    // beq taken on zero, bne on nonzero
    assign pc_en = ctrl.pc_write || (ctrl.pc_write_cond && (zero ^ ctrl.branch_ne));

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
            ir <= '0;
        end else begin
            if (pc_en) begin
                pc <= ctrl.pc_source ? alu_out : alu_result;
            end
            if (ctrl.ir_write) begin
                ir <= mem_rdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.mem_read) begin
            mdr <= mem_rdata;
        end
        a_reg   <= rdata1;
        b_reg   <= rdata2;
        alu_out <= alu_result;
    end

    assign mem_addr  = ctrl.i_or_d ? alu_out : pc;
    assign mem_wdata = b_reg;

endmodule

// ==== rtl/mc_cpu.sv ====
module mc_cpu #(
    parameter int mem_words = 256
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    host_we,
    input  logic [mc_pkg::xlen-1:0] host_addr,
    input  logic [mc_pkg::xlen-1:0] host_wdata,
    output logic [mc_pkg::xlen-1:0] host_rdata,
    output logic                    retire,
    output logic [mc_pkg::xlen-1:0] pc
);

    mc_pkg::ctrl_t           ctrl;
    mc_pkg::opcode_t         opcode;
    logic [2:0]              funct3;
    logic [mc_pkg::xlen-1:0] mem_addr;
    logic [mc_pkg::xlen-1:0] mem_wdata;
    logic [mc_pkg::xlen-1:0] mem_rdata;

    control_unit u_control (
        .clk    (clk),
        .reset  (reset),
        .opcode (opcode),
        .funct3 (funct3),
        .ctrl   (ctrl),
        .retire (retire)
    );

    datapath u_datapath (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .mem_rdata (mem_rdata),
        .opcode    (opcode),
        .funct3    (funct3),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .pc        (pc)
    );

    unified_memory #(
        .mem_words (mem_words)
    ) u_memory (
        .clk        (clk),
        .addr       (mem_addr),
        .we         (ctrl.mem_write),
        .wdata      (mem_wdata),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .rdata      (mem_rdata),
        .host_rdata (host_rdata)
    );

endmodule

// ==== testbench/mc_cpu_checker.sv ====
module mc_cpu_checker (
    input logic           clk,
    input logic           reset,
    input mc_pkg::ctrl_t  ctrl,
    input mc_pkg::state_t state,
    input logic           retire
);

    timeunit 1ns;
    timeprecision 100ps;

    mem_reg_exclusive: assert property (@(posedge clk) !(ctrl.mem_write && ctrl.reg_write))
        else $error("memory write and register write in the same cycle");

    mem_write_state: assert property (@(posedge clk)
        ctrl.mem_write |-> state == mc_pkg::st_mem_access)
        else $error("memory write outside the mem_access state");

    retire_single: assert property (@(posedge clk) disable iff (reset) retire |=> !retire)
        else $error("retire held for two cycles");

    // nothing may change state while the core sits in reset
    quiet_in_reset: assert property (@(posedge clk)
        reset |-> !(ctrl.mem_write || ctrl.reg_write || ctrl.pc_write || ctrl.ir_write || retire))
        else $error("write enable or retire high during reset");

endmodule

// ==== testbench/mc_cpu_tb.sv ====
module mc_cpu_tb;

    timeunit 1ns;
    timeprecision 100ps;

    logic                    clk;
    logic                    reset;
    logic                    host_we;
    logic [mc_pkg::xlen-1:0] host_addr;
    logic [mc_pkg::xlen-1:0] host_wdata;
    logic [mc_pkg::xlen-1:0] host_rdata;
    logic                    retire;
    logic [mc_pkg::xlen-1:0] pc;
    logic [mc_pkg::xlen-1:0] end_pc; // pc right after the last counted retire
    int                      checks;

    mc_cpu #(
        .mem_words (256)
    ) dut (
        .clk        (clk),
        .reset      (reset),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata),
        .retire     (retire),
        .pc         (pc)
    );

    bind control_unit mc_cpu_checker u_checker (
        .clk    (clk),
        .reset  (reset),
        .ctrl   (ctrl),
        .state  (state),
        .retire (retire)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [mc_pkg::xlen-1:0] expected,
                               input logic [mc_pkg::xlen-1:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("Error: %s expected %08h actual %08h", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic load_word(input logic [mc_pkg::xlen-1:0] addr,
                             input logic [mc_pkg::xlen-1:0] word);
        @(posedge clk);
        host_we    <= 1'b1;
        host_addr  <= addr;
        host_wdata <= word;
        @(posedge clk);
        host_we    <= 1'b0;
    endtask

    // release reset, count retire pulses, then hold the core in reset again
    task automatic run_program(input int count);
        int retired;
        int cycles;
        int limit;
        retired = 0;
        cycles  = 0;
        limit   = 5 * count + 20;
        @(posedge clk);
        reset <= 1'b0;
        while (retired < count && cycles < limit) begin
            @(negedge clk);
            cycles++;
            if (retire) retired++;
        end
        if (retired < count) begin
            stop_with_failure($sformatf("timeout after %0d cycles with %0d of %0d retired",
                                        cycles, retired, count));
        end
        @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        end_pc = pc;
    endtask

    task automatic check_memory(input string name, input logic [mc_pkg::xlen-1:0] addr,
                                input logic [mc_pkg::xlen-1:0] expected);
        @(posedge clk);
        host_addr <= addr;
        @(negedge clk);
        check_value(name, expected, host_rdata);
    endtask

    initial begin : main
        int                      fd;
        int                      n;
        int                      done;
        int                      count;
        string                   cmd;
        string                   name;
        string                   rest;
        logic [mc_pkg::xlen-1:0] addr;
        logic [mc_pkg::xlen-1:0] value;
        reset      <= 1'b1;
        host_we    <= 1'b0;
        host_addr  <= '0;
        host_wdata <= '0;
        checks = 0;
        end_pc = '0;
        repeat (4) @(posedge clk);
        fd = $fopen("testbench/mc_cpu_testdata.txt", "r");
        if (fd == 0) stop_with_failure("could not open testbench/mc_cpu_testdata.txt");
        done = 0;
        while (!done) begin
            n = $fscanf(fd, "%s", cmd);
            if (n != 1) begin
                done = 1; // end of file
            end else if (cmd[0] == "#") begin
                n = $fgets(rest, fd);
            end else if (cmd == "L") begin
                n = $fscanf(fd, "%h %h", addr, value);
                if (n != 2) stop_with_failure("malformed L line in the test data");
                load_word(addr, value);
            end else if (cmd == "R") begin
                n = $fscanf(fd, "%d", count);
                if (n != 1) stop_with_failure("malformed R line in the test data");
                run_program(count);
            end else if (cmd == "C") begin
                n = $fscanf(fd, "%s %h %h", name, addr, value);
                if (n != 3) stop_with_failure("malformed C line in the test data");
                check_memory(name, addr, value);
            end else if (cmd == "P") begin
                n = $fscanf(fd, "%s %h", name, value);
                if (n != 2) stop_with_failure("malformed P line in the test data");
                check_value(name, value, end_pc);
            end else begin
                stop_with_failure($sformatf("unknown command %s in the test data", cmd));
            end
        end
        $fclose(fd);
        if (checks > 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            stop_with_failure("the test data held no checks");
        end
    end

endmodule

// ==== testbench/mc_cpu_testdata.txt ====
# L addr word   R count   C name addr expected   P name expected
# branch offsets count from the address after the branch
L 00000000 00700093 # addi x1, x0, 7
L 00000004 FFD00113 # addi x2, x0, -3
L 00000008 002081B3 # add  x3, x1, x2
L 0000000C 40208233 # sub  x4, x1, x2
L 00000010 0020F2B3 # and  x5, x1, x2
L 00000014 0020E333 # or   x6, x1, x2
L 00000018 0020C3B3 # xor  x7, x1, x2
L 0000001C 00112433 # slt  x8, x2, x1
L 00000020 FFE12493 # slti x9, x2, -2
L 00000024 10302023 # sw x3, 0x100(x0)
L 00000028 10402223 # sw x4, 0x104(x0)
L 0000002C 10502423 # sw x5, 0x108(x0)
L 00000030 10602623 # sw x6, 0x10c(x0)
L 00000034 10702823 # sw x7, 0x110(x0)
L 00000038 10802A23 # sw x8, 0x114(x0)
L 0000003C 10902C23 # sw x9, 0x118(x0)
L 00000040 10202E23 # sw x2, 0x11c(x0)
L 00000044 11002503 # lw x10, 0x110(x0)
L 00000048 12A02023 # sw x10, 0x120(x0)
L 0000004C 00500013 # addi x0, x0, 5
L 00000050 12002223 # sw x0, 0x124(x0)
L 00000054 00108263 # beq x1, x1 taken
L 00000058 12102423 # sw x1, 0x128(x0) skipped
L 0000005C 00209263 # bne x1, x2 taken
L 00000060 12102623 # sw x1, 0x12c(x0) skipped
L 00000064 00208263 # beq x1, x2 not taken
L 00000068 12102823 # sw x1, 0x130(x0)
L 0000006C 00109263 # bne x1, x1 not taken
L 00000070 12102A23 # sw x1, 0x134(x0)
L 00000124 DEADBEEF
L 00000128 DEADBEEF
L 0000012C DEADBEEF
R 27
P end_pc 00000074
C add_result 00000100 00000004
C sub_result 00000104 0000000A
C and_result 00000108 00000005
C or_result 0000010C FFFFFFFF
C xor_result 00000110 FFFFFFFA
C slt_result 00000114 00000001
C slti_result 00000118 00000001
C addi_negative 0000011C FFFFFFFD
C load_store_copy 00000120 FFFFFFFA
C x0_is_zero 00000124 00000000
C beq_taken_skip 00000128 DEADBEEF
C bne_taken_skip 0000012C DEADBEEF
C beq_not_taken 00000130 00000007
C bne_not_taken 00000134 00000007

// ==== vlog.f ====
rtl/mc_pkg.sv
rtl/alu.sv
rtl/register_file.sv
rtl/unified_memory.sv
rtl/control_unit.sv
rtl/datapath.sv
rtl/mc_cpu.sv
testbench/mc_cpu_checker.sv
testbench/mc_cpu_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := mc_cpu_tb
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
